//--- verif/m68kSdramPatterns.txt
# op address data strobes(UDS_L LDS_L, 0 = active) expected
# W write, R read, H read holding AS_L, I idle stretch
W 00000010 1234 00 0000
R 00000010 0000 00 1234
W 0100a822 beef 00 0000
R 0100a822 0000 00 beef
W 02fff7fe 5a5a 00 0000
R 02fff7fe 0000 00 5a5a
W 03123456 c3a7 00 0000
R 03123456 0000 00 c3a7
W 00000010 ab77 01 0000
R 00000010 0000 00 ab34
W 0100a822 11cd 10 0000
R 0100a822 0000 00 becd
I 00000000 0000 11 0000
R 02fff7fe 0000 00 5a5a
R 00000010 0000 00 ab34
W 03123456 9999 00 0000
H 03123456 0000 00 9999

//--- m68kSdramCtrl.f
+incdir+design
design/sdramCtrlPkg.sv
design/cpuBusFrontEnd.sv
design/sdramSequencer.sv
design/sdramPhy.sv
design/m68kSdramCtrl.sv
verif/sdramModel.sv
verif/m68kSdramCtrlTb.sv

//--- runSim.sh
#!/bin/sh
# build and run the controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f m68kSdramCtrl.f --top-module m68kSdramCtrlTb -o simv
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" sim.log; then
	exit 1
fi
exit 0

//--- verif/m68kSdramCtrlTb.sv
// 68000 SDRAM controller testbench
`timescale 1ns/1ps
`include "sdramCtrl_params.svh"

module m68kSdramCtrlTb;

	localparam int DtackLimit = 200;                 // dtack wait in cycles incl a pending refresh
	localparam int HoldCycles = 4;                   // extra AS_L low cycles on H lines
	localparam int InitCycles = `POWERUP_CYCLES + `INIT_REFRESHES * (`REFRESH_GAP + 1)
		+ `MRS_WAIT + 16;

	logic                      Clock = 1'b0;
	logic                      Reset_L;
	logic [31:0]               Address;
	logic [`SDRAM_DATA_W-1:0]  DataIn;
	logic                      UDS_L, LDS_L, AS_L, WE_L, DramSelect_L;
	logic [`SDRAM_DATA_W-1:0]  DataOut;
	logic                      Dtack_L, ResetOut_L;
	logic                      SDram_CKE, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L;
	logic [`SDRAM_ROW_W-1:0]   SDram_Addr;
	logic [`SDRAM_BANK_W-1:0]  SDram_BA;
	logic [1:0]                SDram_DQM;
	wire  [`SDRAM_DATA_W-1:0]  SDram_DQ;
	int                        refreshes, activates, protoErrors;
	logic                      initOk;

	logic [7:0]                opList [$];       // W, R, H or I
	logic [31:0]               addrList [$];
	logic [15:0]               dataList [$];
	logic [1:0]                strobeList [$];   // {UDS_L, LDS_L}
	logic [15:0]               expList [$];
	logic [15:0]               shadow [logic [24:0]];
	int                        errors = 0;
	int                        seed = 32'h1d3e;
	int                        patternCount = 0;
	logic                      loaded = 1'b0;
	logic                      dtackLost = 1'b0;

	always #2 Clock = ~Clock;                    // 4 ns period

	m68kSdramCtrl dut0 (.*);

	sdramModel model0 (
		.Clock, .CKE(SDram_CKE), .CS_L(SDram_CS_L), .RAS_L(SDram_RAS_L),
		.CAS_L(SDram_CAS_L), .WE_L(SDram_WE_L), .Addr(SDram_Addr), .BA(SDram_BA),
		.DQM(SDram_DQM), .DQ(SDram_DQ), .refreshes, .activates, .protoErrors, .initOk
	);

	task automatic reportValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Error %s: got %h expected %h at %0t", name, got, exp, $time);
		errors++;
	endtask

	task automatic finishRun();
		$display("errors: checks %0d, protocol %0d", errors, protoErrors);
		if (errors == 0 && protoErrors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	endtask

	task automatic loadPatterns();
		int             fd;
		string          line;
		logic [7:0]     op;
		logic [31:0]    a;
		logic [15:0]    d, e;
		logic [1:0]     s;
		fd = $fopen("verif/m68kSdramPatterns.txt", "r");
		if (fd == 0) begin
			$display("could not open the pattern file");
			errors++;
		end else begin
			while ($fgets(line, fd) > 0) begin
				if (line.len() > 1 && line[0] != "#"
					&& $sscanf(line, "%c %h %h %b %h", op, a, d, s, e) == 5) begin
					opList.push_back(op);
					addrList.push_back(a);
					dataList.push_back(d);
					strobeList.push_back(s);
					expList.push_back(e);
				end
			end
			$fclose(fd);
		end
		patternCount = opList.size();
		loaded = 1'b1;
	endtask

	////////////////////////////////////////////////////////////
	// one 68000 bus cycle with inputs changing on the falling edge
	////////////////////////////////////////////////////////////
	task automatic busCycle(input logic isWrite, input logic [31:0] addr,
		input logic [15:0] data, input logic [1:0] strobes, input int hold,
		output logic [15:0] rdValue);
		int waited;
		int idle;
		int activatesBefore;
		waited = 0;
		@(negedge Clock);
		Address      = addr;
		DataIn       = data;
		WE_L         = !isWrite;
		DramSelect_L = 1'b0;
		AS_L         = 1'b0;
		if (isWrite)
			@(negedge Clock);                        // write strobes lag AS_L
		{UDS_L, LDS_L} = strobes;
		while (Dtack_L) begin
			@(negedge Clock);
			waited++;
			if (waited > DtackLimit)
				dtackLost = 1'b1;                    // watchdog ends the run
		end
		rdValue = DataOut;
		activatesBefore = activates;
		repeat (hold) begin                          // cpu stretches the cycle
			@(negedge Clock);
			if (Dtack_L !== 1'b0)
				reportValue("Dtack_L during hold", 32'(Dtack_L), 32'h0);
		end
		if (activates != activatesBefore)
			reportValue("activates during hold", activates, activatesBefore);
		AS_L         = 1'b1;
		UDS_L        = 1'b1;
		LDS_L        = 1'b1;
		DramSelect_L = 1'b1;
		WE_L         = 1'b1;
		@(negedge Clock);
		if (Dtack_L !== 1'b1)
			reportValue("Dtack_L after release", 32'(Dtack_L), 32'h1);
		idle = {$random(seed)} % 6;
		repeat (idle) @(negedge Clock);
	endtask

	initial begin : stimulus
		logic [15:0]  rdValue;
		logic [15:0]  merged;
		logic [24:0]  key;
		int           refreshesBefore;
		Reset_L      = 1'b0;
		Address      = '0;
		DataIn       = '0;
		UDS_L        = 1'b1;
		LDS_L        = 1'b1;
		AS_L         = 1'b1;
		WE_L         = 1'b1;
		DramSelect_L = 1'b1;
		loadPatterns();
		repeat (2) @(posedge Clock);
		@(negedge Clock);
		if (Dtack_L !== 1'b1)
			reportValue("Dtack_L in reset", 32'(Dtack_L), 32'h1);
		if (ResetOut_L !== 1'b0)
			reportValue("ResetOut_L in reset", 32'(ResetOut_L), 32'h0);
		if (SDram_CKE !== 1'b0)
			reportValue("SDram_CKE in reset", 32'(SDram_CKE), 32'h0);
		if (SDram_CS_L !== 1'b1)                     // deselect
			reportValue("SDram_CS_L in reset", 32'(SDram_CS_L), 32'h1);
		Reset_L = 1'b1;
		wait (ResetOut_L === 1'b1);
		@(negedge Clock);
		if (initOk !== 1'b1) begin
			$display("ResetOut_L rose before the SDRAM saw the full init sequence");
			errors++;
		end
		for (int i = 0; i < patternCount; i++) begin
			key = addrList[i][25:1];                 // bank, row, column
			case (opList[i])
				"W": begin
					merged = shadow.exists(key) ? shadow[key] : '0;
					if (!strobeList[i][1])
						merged[15:8] = dataList[i][15:8];
					if (!strobeList[i][0])
						merged[7:0] = dataList[i][7:0];
					shadow[key] = merged;
					busCycle(1'b1, addrList[i], dataList[i], strobeList[i], 0, rdValue);
				end
				"R", "H": begin
					busCycle(1'b0, addrList[i], 16'h0, strobeList[i],
						opList[i] == "H" ? HoldCycles : 0, rdValue);
					if (rdValue !== expList[i])
						reportValue("DataOut", 32'(rdValue), 32'(expList[i]));
					if (shadow.exists(key) && rdValue !== shadow[key])
						reportValue("DataOut vs merged writes", 32'(rdValue), 32'(shadow[key]));
				end
				"I": begin
					refreshesBefore = refreshes;
					repeat (2 * `REFRESH_INTERVAL) @(negedge Clock);
					if (refreshes <= refreshesBefore) begin
						$display("no refresh reached the SDRAM during the idle stretch");
						errors++;
					end
				end
				default: begin
					$display("unknown operation in the pattern file");
					errors++;
				end
			endcase
		end
		finishRun();
	end

	initial begin : watchdog
		int limit;
		int cycles;
		cycles = 0;
		wait (loaded);
		limit = patternCount * 40 + InitCycles + 2 * `REFRESH_INTERVAL;
		while (!dtackLost && cycles < limit) begin
			@(posedge Clock);
			cycles++;
		end
		if (dtackLost)
			$display("Dtack_L never arrived, bus cycle abandoned");
		else
			$display("simulation ran past its time limit");
		errors++;
		finishRun();
	end

endmodule

//--- verif/sdramModel.sv
// Behavioral SDRAM model
`timescale 1ns/1ps
`include "sdramCtrl_params.svh"

module sdramModel (
	input  logic                       Clock,
	input  logic                       CKE,
	input  logic                       CS_L,
	input  logic                       RAS_L,
	input  logic                       CAS_L,
	input  logic                       WE_L,
	input  logic [`SDRAM_ROW_W-1:0]    Addr,
	input  logic [`SDRAM_BANK_W-1:0]   BA,
	input  logic [1:0]                 DQM,           // high masks the byte
	inout  wire  [`SDRAM_DATA_W-1:0]   DQ,
	output int                         refreshes,     // every auto refresh seen
	output int                         activates,     // one per access
	output int                         protoErrors,
	output logic                       initOk         // full init order seen at mode set
);

	// {cs, ras, cas, we} from the device truth table
	localparam logic [3:0] Activate  = 4'b0011;
	localparam logic [3:0] Read      = 4'b0101;
	localparam logic [3:0] Write     = 4'b0100;
	localparam logic [3:0] Precharge = 4'b0010;
	localparam logic [3:0] Refresh   = 4'b0001;
	localparam logic [3:0] ModeSet   = 4'b0000;
	// single write (A9), cas latency in A6..A4, sequential burst of 1
	localparam logic [12:0] ExpMode  = 13'h200 | 13'(`CAS_LATENCY << 4);

	logic [`SDRAM_DATA_W-1:0] mem [logic [24:0]];    // sparse store keyed by {bank, row, col}
	logic [`SDRAM_ROW_W-1:0]  openRow [4];
	logic [3:0]               rowOpen;
	logic                     modeSet, sawCkeLow, sawPrechAll;
	logic                     driveEn;
	logic [`SDRAM_DATA_W-1:0] dqOut, rdData, word;
	logic [24:0]              key;
	logic [3:0]               cmd;
	int                       rdWait;                // edges until read data

	assign cmd = {CS_L, RAS_L, CAS_L, WE_L};
	assign key = {BA, openRow[BA], Addr[`SDRAM_COL_W-1:0]};
	assign DQ  = driveEn ? dqOut : 'z;

	task automatic flagError(input string msg);
		$display("SDRAM model at %0t: %s", $time, msg);
		protoErrors++;
	endtask

	////////////////////////////////////////////////////////////
	// command decode
	////////////////////////////////////////////////////////////
	always @(posedge Clock) begin
		driveEn <= 1'b0;                             // data valid for one cycle
		if (rdWait > 0)
			rdWait <= rdWait - 1;
		if (rdWait == 1) begin
			driveEn <= 1'b1;
			dqOut   <= rdData;
		end
		if (!CKE) begin                              // cke low clears the device state
			sawCkeLow   <= 1'b1;
			sawPrechAll <= 1'b0;
			modeSet     <= 1'b0;
			initOk      <= 1'b0;
			rowOpen     <= '0;
			rdWait      <= 0;
			refreshes   = 0;
			activates   = 0;
			protoErrors = 0;
		end else if (!CS_L) begin
			if (!modeSet && (cmd == Activate || cmd == Read || cmd == Write))
				flagError("access before the mode register was set");
			case (cmd)
				Activate: begin
					rowOpen[BA] <= 1'b1;
					openRow[BA] <= Addr;
					activates++;
				end
				Read, Write: begin
					if (!rowOpen[BA])
						flagError($sformatf("read or write to bank %0d with no open row",
							BA));
					if (Addr[10])
						rowOpen[BA] <= 1'b0;             // auto precharge closes the row
					if (cmd == Write) begin
						word = mem.exists(key) ? mem[key] : '0;
						if (!DQM[1])
							word[15:8] = DQ[15:8];
						if (!DQM[0])
							word[7:0] = DQ[7:0];
						mem[key] = word;
					end else begin
						rdData <= mem.exists(key) ? mem[key] : '0;
						rdWait <= `CAS_LATENCY;
					end
				end
				Precharge: begin
					if (Addr[10]) begin                  // all banks
						rowOpen     <= '0;
						sawPrechAll <= 1'b1;
						if (!modeSet)
							refreshes = 0;               // init refreshes count from here
					end
				end
				Refresh: refreshes++;
				ModeSet: begin
					modeSet <= 1'b1;
					if (Addr != ExpMode)
						flagError($sformatf("mode register loaded with %h", Addr));
					initOk <= sawCkeLow && sawPrechAll && refreshes == `INIT_REFRESHES
						&& Addr == ExpMode;
				end
				default: ;
			endcase
		end
	end

endmodule

//--- design/m68kSdramCtrl.sv
// 68000 SDRAM controller top
`timescale 1ns/1ps
`include "sdramCtrl_params.svh"

module m68kSdramCtrl (
	input  logic                        Clock,
	input  logic                        Reset_L,
	input  logic [31:0]                 Address,
	input  logic [`SDRAM_DATA_W-1:0]    DataIn,
	input  logic                        UDS_L,
	input  logic                        LDS_L,
	input  logic                        AS_L,
	input  logic                        WE_L,
	input  logic                        DramSelect_L,
	output logic [`SDRAM_DATA_W-1:0]    DataOut,
	output logic                        Dtack_L,
	output logic                        ResetOut_L,     // cpu reset until init ends
	output logic                        SDram_CKE,
	output logic                        SDram_CS_L,
	output logic                        SDram_RAS_L,
	output logic                        SDram_CAS_L,
	output logic                        SDram_WE_L,
	output logic [`SDRAM_ROW_W-1:0]     SDram_Addr,
	output logic [`SDRAM_BANK_W-1:0]    SDram_BA,
	output logic [1:0]                  SDram_DQM,
	inout  wire  [`SDRAM_DATA_W-1:0]    SDram_DQ
);

	sdramCtrlPkg::cpuReq_t      request;           // front end to sequencer
	logic                       req;
	logic                       ack;
	sdramCtrlPkg::phyCtrl_t     phy;               // sequencer to pin stage
	logic [`SDRAM_DATA_W-1:0]   rdata;             // pin stage to front end

	cpuBusFrontEnd frontEnd0 (
		.Clock, .Reset_L, .Address, .DataIn, .UDS_L, .LDS_L, .AS_L, .WE_L,
		.DramSelect_L, .DataOut, .Dtack_L, .request, .req, .ack, .rdata
	);

	sdramSequencer sequencer0 (
		.Clock, .Reset_L, .request, .req, .ack, .phy, .ResetOut_L
	);

	sdramPhy phy0 (
		.Clock, .Reset_L, .phy, .SDram_CKE, .SDram_CS_L, .SDram_RAS_L,
		.SDram_CAS_L, .SDram_WE_L, .SDram_Addr, .SDram_BA, .SDram_DQM,
		.SDram_DQ, .rdata
	);

endmodule

//--- design/sdramPhy.sv
// SDRAM pin stage
`timescale 1ns/1ps
`include "sdramCtrl_params.svh"

module sdramPhy (
	input  logic                        Clock,
	input  logic                        Reset_L,
	input  sdramCtrlPkg::phyCtrl_t      phy,
	output logic                        SDram_CKE,
	output logic                        SDram_CS_L,
	output logic                        SDram_RAS_L,
	output logic                        SDram_CAS_L,
	output logic                        SDram_WE_L,
	output logic [`SDRAM_ROW_W-1:0]     SDram_Addr,
	output logic [`SDRAM_BANK_W-1:0]    SDram_BA,
	output logic [1:0]                  SDram_DQM,
	inout  wire  [`SDRAM_DATA_W-1:0]    SDram_DQ,
	output logic [`SDRAM_DATA_W-1:0]    rdata       // held until next capture
);

	sdramCtrlPkg::sdramCmd_t    cmdReg;
	logic                       driveReg;          // dq output enable
	logic                       captureReg;
	logic [`SDRAM_DATA_W-1:0]   wdataReg;

	////////////////////////////////////////////////////////////
	// rising edge pin registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			SDram_CKE  <= 1'b0;                      // cke low through power up
			cmdReg     <= sdramCtrlPkg::CMD_DESELECT;
			driveReg   <= 1'b0;                      // dq released
			captureReg <= 1'b0;
		end else begin
			SDram_CKE  <= phy.cke;
			cmdReg     <= phy.cmd;
			driveReg   <= phy.drive;
			captureReg <= phy.capture;
		end
	end

	always_ff @(posedge Clock) begin
		SDram_Addr <= phy.addr;
		SDram_BA   <= phy.ba;
		SDram_DQM  <= phy.dqm;
		wdataReg   <= phy.wdata;
	end

	assign {SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} = cmdReg;
	assign SDram_DQ = driveReg ? wdataReg : 'z;   // tristate unless writing

	// read data is sampled mid cycle, clear of the dq edges
	always_ff @(negedge Clock) begin
		if (captureReg)
			rdata <= SDram_DQ;
	end

	// dq drive on the pins lines up with the write command
	driveWithWrite: assert property (
		@(posedge Clock) disable iff (!Reset_L)
		phy.drive |=> (!SDram_CS_L && SDram_RAS_L && !SDram_CAS_L && !SDram_WE_L)
	) else $error("dq driven outside a write");

endmodule

//--- design/sdramSequencer.sv
// SDRAM command sequencer
`timescale 1ns/1ps
`include "sdramCtrl_params.svh"

module sdramSequencer (
	input  logic                   Clock,
	input  logic                   Reset_L,
	input  sdramCtrlPkg::cpuReq_t  request,
	input  logic                   req,
	output logic                   ack,
	output sdramCtrlPkg::phyCtrl_t phy,        // registered again by the pin stage
	output logic                   ResetOut_L
);

	localparam int RefCntW = $clog2(`INIT_REFRESHES + 1);

	sdramCtrlPkg::seqState_t state;
	sdramCtrlPkg::seqState_t nextState;

	logic [`TIMER_W-1:0] timer;               // general delay counting down to 0
	logic [`TIMER_W-1:0] timerValue;
	logic                timerLoad;
	logic                timerDone;
	logic [`TIMER_W-1:0] refTimer;            // periodic refresh interval
	logic                refLoad;
	logic                refDue;
	logic [RefCntW-1:0]  refLeft;             // refreshes still to issue
	logic                initDone;

	assign timerDone  = (timer == '0);
	assign refDue     = (refTimer == '0);
	assign ResetOut_L = initDone;             // cpu held until init ends

	////////////////////////////////////////////////////////////
	// state, timers and counters
	////////////////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state    <= sdramCtrlPkg::ST_POWERUP;
			timer    <= '0;
			refTimer <= '0;
			refLeft  <= '0;
			initDone <= 1'b0;
			ack      <= 1'b0;
		end else begin
			state <= nextState;
			if (timerLoad)
				timer <= timerValue;
			else if (!timerDone)
				timer <= timer - 1'b1;
			if (refLoad)
				refTimer <= `TIMER_W'(`REFRESH_INTERVAL);
			else if (!refDue)
				refTimer <= refTimer - 1'b1;
			if (state == sdramCtrlPkg::ST_PRECHARGE)      // one refresh once running
				refLeft <= initDone ? RefCntW'(1) : RefCntW'(`INIT_REFRESHES);
			else if (state == sdramCtrlPkg::ST_REFRESH)
				refLeft <= refLeft - 1'b1;
			if (state == sdramCtrlPkg::ST_MODEWAIT && timerDone)
				initDone <= 1'b1;
			ack <= (state == sdramCtrlPkg::ST_DONE) && req;  // drops a cycle after req
		end
	end

	////////////////////////////////////////////////////////////
	// next state and pin control
	////////////////////////////////////////////////////////////
	always_comb begin
		nextState  = state;
		phy        = '0;
		phy.cke    = 1'b1;
		phy.cmd    = sdramCtrlPkg::CMD_NOP;
		timerLoad  = 1'b0;
		timerValue = '0;
		refLoad    = 1'b0;
		case (state)
			sdramCtrlPkg::ST_POWERUP: begin
				phy.cke    = 1'b0;
				phy.cmd    = sdramCtrlPkg::CMD_DESELECT;
				timerLoad  = 1'b1;
				timerValue = `TIMER_W'(`POWERUP_CYCLES - 1);
				nextState  = sdramCtrlPkg::ST_POWERWAIT;
			end
			sdramCtrlPkg::ST_POWERWAIT: begin
				phy.cke = 1'b0;                      // cke low for the whole wait
				phy.cmd = sdramCtrlPkg::CMD_DESELECT;
				if (timerDone)
					nextState = sdramCtrlPkg::ST_FIRSTNOP;
			end
			sdramCtrlPkg::ST_FIRSTNOP:
				nextState = sdramCtrlPkg::ST_PRECHARGE;
			sdramCtrlPkg::ST_PRECHARGE: begin
				phy.cmd           = sdramCtrlPkg::CMD_PRECHARGE;
				phy.addr[`AP_BIT] = 1'b1;            // all banks
				nextState         = sdramCtrlPkg::ST_REFRESH;
			end
			sdramCtrlPkg::ST_REFRESH: begin
				phy.cmd    = sdramCtrlPkg::CMD_REFRESH;
				timerLoad  = 1'b1;
				timerValue = `TIMER_W'(`REFRESH_GAP - 1);
				nextState  = sdramCtrlPkg::ST_REFRESHGAP;
			end
			sdramCtrlPkg::ST_REFRESHGAP: begin
				if (timerDone) begin
					if (refLeft != '0)
						nextState = sdramCtrlPkg::ST_REFRESH;
					else if (initDone)
						nextState = sdramCtrlPkg::ST_IDLE;
					else
						nextState = sdramCtrlPkg::ST_MODESET;
				end
			end
			sdramCtrlPkg::ST_MODESET: begin
				phy.cmd    = sdramCtrlPkg::CMD_MODESET;
				phy.addr   = `MODE_WORD;             // ba stays 0
				timerLoad  = 1'b1;
				timerValue = `TIMER_W'(`MRS_WAIT - 1);
				nextState  = sdramCtrlPkg::ST_MODEWAIT;
			end
			sdramCtrlPkg::ST_MODEWAIT: begin
				if (timerDone) begin
					refLoad   = 1'b1;                // start refresh interval
					nextState = sdramCtrlPkg::ST_IDLE;
				end
			end
			sdramCtrlPkg::ST_IDLE: begin
				if (refDue) begin                    // refresh wins over the cpu
					refLoad   = 1'b1;
					nextState = sdramCtrlPkg::ST_PRECHARGE;
				end else if (req)
					nextState = sdramCtrlPkg::ST_ACTIVATE;
			end
			sdramCtrlPkg::ST_ACTIVATE: begin
				phy.cmd   = sdramCtrlPkg::CMD_ACTIVATE;
				phy.addr  = request.row;
				phy.ba    = request.bank;
				nextState = request.write ? sdramCtrlPkg::ST_WRITE : sdramCtrlPkg::ST_READ;
			end
			sdramCtrlPkg::ST_WRITE: begin
				phy.cmd                     = sdramCtrlPkg::CMD_WRITE;
				phy.addr[`SDRAM_COL_W-1:0]  = request.col;
				phy.addr[`AP_BIT]           = 1'b1;  // auto precharge
				phy.ba                      = request.bank;
				phy.dqm                     = ~request.byteEn;
				phy.drive                   = 1'b1;
				phy.wdata                   = request.wdata;
				nextState                   = sdramCtrlPkg::ST_DONE;
			end
			sdramCtrlPkg::ST_READ: begin
				phy.cmd                     = sdramCtrlPkg::CMD_READ;
				phy.addr[`SDRAM_COL_W-1:0]  = request.col;
				phy.addr[`AP_BIT]           = 1'b1;
				phy.ba                      = request.bank;
				timerLoad                   = 1'b1;
				timerValue                  = `TIMER_W'(`CAS_LATENCY);
				nextState                   = sdramCtrlPkg::ST_CASWAIT;
			end
			sdramCtrlPkg::ST_CASWAIT: begin
				if (timerDone) begin                 // lands cas+1 pin cycles after read
					phy.capture = 1'b1;
					nextState   = sdramCtrlPkg::ST_DONE;
				end
			end
			sdramCtrlPkg::ST_DONE: begin
				if (!req)
					nextState = sdramCtrlPkg::ST_IDLE;
			end
			default: nextState = sdramCtrlPkg::ST_POWERUP;
		endcase
	end

	// column commands follow an activate of the same bank
	colAfterActivate: assert property (
		@(posedge Clock) disable iff (!Reset_L)
		(phy.cmd inside {sdramCtrlPkg::CMD_READ, sdramCtrlPkg::CMD_WRITE})
			|-> $past(phy.cmd) == sdramCtrlPkg::CMD_ACTIVATE && $past(phy.ba) == phy.ba
	) else $error("read or write without activate");

endmodule

//--- design/cpuBusFrontEnd.sv
// 68000 bus front end
`timescale 1ns/1ps
`include "sdramCtrl_params.svh"

module cpuBusFrontEnd (
	input  logic                       Clock,
	input  logic                       Reset_L,
	input  logic [31:0]                Address,       // cpu byte address
	input  logic [`SDRAM_DATA_W-1:0]   DataIn,        // write data from cpu
	input  logic                       UDS_L,         // D15..D8 strobe
	input  logic                       LDS_L,         // D7..D0 strobe
	input  logic                       AS_L,
	input  logic                       WE_L,          // low for write
	input  logic                       DramSelect_L,  // address decode for dram
	output logic [`SDRAM_DATA_W-1:0]   DataOut,       // read data to cpu
	output logic                       Dtack_L,
	output sdramCtrlPkg::cpuReq_t      request,       // held through handshake
	output logic                       req,
	input  logic                       ack,
	input  logic [`SDRAM_DATA_W-1:0]   rdata          // captured by pin stage
);

	sdramCtrlPkg::feState_t state;
	logic                   busCycle;                 // selected cycle with a strobe

	// writes bring the strobes after AS_L, so wait for one of them
	assign busCycle = !AS_L && !DramSelect_L && (!UDS_L || !LDS_L);

	// pin stage holds rdata until the next read
	assign DataOut = rdata;

	////////////////////////////////////////////////////////////
	// handshake fsm
	////////////////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state   <= sdramCtrlPkg::FE_IDLE;
			req     <= 1'b0;
			Dtack_L <= 1'b1;
		end else begin
			case (state)
				sdramCtrlPkg::FE_IDLE: begin
					if (busCycle && !ack) begin    // previous ack must be gone
						req   <= 1'b1;
						state <= sdramCtrlPkg::FE_REQ;
					end
				end
				sdramCtrlPkg::FE_REQ: begin
					if (ack) begin
						Dtack_L <= 1'b0;           // end the cpu cycle
						state   <= sdramCtrlPkg::FE_ACK;
					end
				end
				sdramCtrlPkg::FE_ACK: begin
					if (AS_L) begin                // cpu released the bus
						Dtack_L <= 1'b1;
						req     <= 1'b0;
						state   <= sdramCtrlPkg::FE_IDLE;
					end
				end
				default: state <= sdramCtrlPkg::FE_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// request capture
	////////////////////////////////////////////////////////////
	always_ff @(posedge Clock) begin
		if (state == sdramCtrlPkg::FE_IDLE && busCycle && !ack) begin
			request.write  <= !WE_L;
			request.bank   <= Address[`BANK_FIELD_LSB +: `SDRAM_BANK_W];
			request.row    <= Address[`ROW_FIELD_LSB +: `SDRAM_ROW_W];
			request.col    <= Address[`COL_FIELD_LSB +: `SDRAM_COL_W];
			request.byteEn <= {!UDS_L, !LDS_L};   // strobes to byte enables
			request.wdata  <= DataIn;
		end
	end

	// sequencer must have answered before the request goes away
	reqHeldUntilAck: assert property (
		@(posedge Clock) disable iff (!Reset_L)
		$fell(req) |-> ack
	) else $error("req dropped before ack");

endmodule

//--- design/sdramCtrlPkg.sv
// SDRAM controller types
`include "sdramCtrl_params.svh"

package sdramCtrlPkg;

	// {cs_n, ras_n, cas_n, we_n}
	typedef enum logic [3:0] {
		CMD_MODESET   = 4'b0000,
		CMD_REFRESH   = 4'b0001,
		CMD_PRECHARGE = 4'b0010,       // A10 high selects all banks
		CMD_ACTIVATE  = 4'b0011,
		CMD_WRITE     = 4'b0100,       // A10 high for auto precharge
		CMD_READ      = 4'b0101,       // A10 high for auto precharge
		CMD_NOP       = 4'b0111,
		CMD_DESELECT  = 4'b1111
	} sdramCmd_t;

	typedef enum logic [4:0] {
		ST_POWERUP, ST_POWERWAIT, ST_FIRSTNOP, ST_PRECHARGE,
		ST_REFRESH, ST_REFRESHGAP, ST_MODESET, ST_MODEWAIT,
		ST_IDLE, ST_ACTIVATE, ST_READ, ST_CASWAIT, ST_WRITE, ST_DONE
	} seqState_t;

	typedef enum logic [1:0] {
		FE_IDLE,                       // waiting for a selected bus cycle
		FE_REQ,                        // req up, waiting on ack
		FE_ACK                         // dtack out, waiting on AS_L high
	} feState_t;

	typedef struct packed {
		logic                      write;    // 1 = write cycle
		logic [`SDRAM_BANK_W-1:0]  bank;
		logic [`SDRAM_ROW_W-1:0]   row;
		logic [`SDRAM_COL_W-1:0]   col;
		logic [1:0]                byteEn;   // {upper, lower}, active high
		logic [`SDRAM_DATA_W-1:0]  wdata;
	} cpuReq_t;

	typedef struct packed {
		logic                      cke;
		sdramCmd_t                 cmd;
		logic [`SDRAM_ROW_W-1:0]   addr;
		logic [`SDRAM_BANK_W-1:0]  ba;
		logic [1:0]                dqm;      // high masks the byte
		logic                      drive;    // enable dq output
		logic [`SDRAM_DATA_W-1:0]  wdata;
		logic                      capture;  // sample dq on falling edge
	} phyCtrl_t;

endpackage

//--- design/sdramCtrl_params.svh
// SDRAM controller constants
`ifndef SDRAMCTRL_PARAMS_SVH
`define SDRAMCTRL_PARAMS_SVH

// device geometry, 4 banks x 8192 rows x 1024 cols x 16 bits
`define SDRAM_ROW_W       13        // row address width
`define SDRAM_COL_W       10        // column address width
`define SDRAM_BANK_W      2         // bank address width
`define SDRAM_DATA_W      16        // dq width

// cpu address split, byte address so A0 is not used
`define ROW_FIELD_LSB     11        // row is A23..A11
`define BANK_FIELD_LSB    24        // bank is A25..A24
`define COL_FIELD_LSB     1         // column is A10..A1
`define AP_BIT            10        // A10, auto precharge / all banks

// init and refresh timing in controller clocks
`define POWERUP_CYCLES    8         // cut down from 100us for simulation
`define INIT_REFRESHES    8         // auto refreshes before mode set
`define REFRESH_GAP       3         // nops after each refresh
`define MODE_WORD         13'h220   // burst 1, cas 2, single write
`define MRS_WAIT          3         // nops after mode set
`define REFRESH_INTERVAL  375       // 7.5us at 50MHz
`define CAS_LATENCY       2         // read data delay

// both timers share one width
`define TIMER_W           16

`endif
